/* hdl/sifhPkg.sv */
`default_nettype none

package sifhPkg;

    // field widths
    localparam int BIN_W   = 4;               // time-bin index
    localparam int PIX_W   = 2;               // pixel index
    localparam int ADDR_W  = PIX_W + BIN_W;   // pixel on top, bin below
    localparam int COUNT_W = 8;
    localparam int SHOT_W  = 10;              // photons per frame

    // sizes derived from the widths
    localparam int BIN_NUM   = 1 << BIN_W;    // 16 bins per pixel
    localparam int PIXEL_NUM = 1 << PIX_W;    // 4 pixels
    localparam int RAM_DEPTH = BIN_NUM * PIXEL_NUM;
    localparam int COUNT_MAX = (1 << COUNT_W) - 1;  // bin saturates here

    typedef logic [BIN_W-1:0]   binT;
    typedef logic [PIX_W-1:0]   pixT;
    typedef logic [ADDR_W-1:0]  addrT;
    typedef logic [COUNT_W-1:0] countT;
    typedef logic [SHOT_W-1:0]  shotT;

    typedef enum logic [2:0] {
        CLEAR,  // zero the whole histogram SRAM
        IDLE,   // waiting for start
        BUILD,  // accepting photon events
        DRAIN,  // last read-modify-write retires
        FIND    // peak scan over all bins
    } ctrlStateT;

endpackage

`default_nettype wire

/* hdl/histRam.sv */
`timescale 1ns/1ps
`default_nettype none

module histRam (
    input  wire                   clk,
    input  wire                   wEn,
    input  wire sifhPkg::addrT    wAddr,
    input  wire sifhPkg::countT   wData,
    input  wire                   rEn,
    input  wire sifhPkg::addrT    rAddr,
    output sifhPkg::countT        rData
);

    sifhPkg::countT mem [sifhPkg::RAM_DEPTH];  // one word per pixel and bin

    // write port
    always_ff @(posedge clk) begin
        if (wEn) begin
            mem[wAddr] <= wData;
        end
    end

    // registered read, returns old data on a same-address write
    always_ff @(posedge clk) begin
        if (rEn) begin
            rData <= mem[rAddr];
        end
    end

endmodule

`default_nettype wire

/* hdl/histBuilder.sv */
`timescale 1ns/1ps
`default_nettype none

module histBuilder (
    input  wire                   clk,
    input  wire                   res,
    input  wire                   hitValid,
    input  wire sifhPkg::addrT    hitAddr,
    output logic                  rdEn,
    output sifhPkg::addrT         rdAddr,
    input  wire sifhPkg::countT   rdData,
    output logic                  wrEn,
    output sifhPkg::addrT         wrAddr,
    output sifhPkg::countT        wrData
);

    logic           s2Valid;    // hit waiting for its read data
    sifhPkg::addrT  s2Addr;
    logic           lastValid;  // a write went out last cycle
    sifhPkg::addrT  lastAddr;
    sifhPkg::countT lastData;
    logic           bypass;
    sifhPkg::countT curCount;

    // stage 1: read issued in the same cycle as the hit
    assign rdEn   = hitValid;
    assign rdAddr = hitAddr;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s2Valid   <= 1'b0;
            lastValid <= 1'b0;
        end else begin
            s2Valid   <= hitValid;
            lastValid <= wrEn;
        end
    end

    always_ff @(posedge clk) begin
        s2Addr   <= hitAddr;
        lastAddr <= wrAddr;
        lastData <= wrData;
    end

    // stage 2: the SRAM read raced the previous write to the same word
    assign bypass   = lastValid && (lastAddr == s2Addr);
    assign curCount = bypass ? lastData : rdData;

    assign wrEn   = s2Valid;
    assign wrAddr = s2Addr;
    always_comb begin
        if (curCount == sifhPkg::countT'(sifhPkg::COUNT_MAX)) begin
            wrData = curCount;  // saturate
        end else begin
            wrData = curCount + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hdl/peakFinder.sv */
`timescale 1ns/1ps
`default_nettype none

module peakFinder (
    input  wire                   clk,
    input  wire                   res,
    input  wire                   findStart,
    output logic                  rdEn,
    output sifhPkg::addrT         rdAddr,
    input  wire sifhPkg::countT   rdData,
    output logic                  pkWrite,
    output sifhPkg::pixT          pkPixel,
    output sifhPkg::binT          pkBin,
    output sifhPkg::countT        pkCount,
    output logic                  findDone
);

    logic           dValid;     // rdData holds a word this cycle
    sifhPkg::addrT  dAddr;      // address of that word
    sifhPkg::pixT   dPix;
    sifhPkg::binT   dBin;
    sifhPkg::countT maxCount;   // running peak of the current pixel
    sifhPkg::binT   maxBin;
    logic           take;
    sifhPkg::countT nextCount;
    sifhPkg::binT   nextBin;

    assign {dPix, dBin} = dAddr;

    // first bin always loads, later bins only if strictly greater
    assign take      = (dBin == '0) || (rdData > maxCount);
    assign nextCount = take ? rdData : maxCount;
    assign nextBin   = take ? dBin : maxBin;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            rdEn     <= 1'b0;
            rdAddr   <= '0;
            dValid   <= 1'b0;
            pkWrite  <= 1'b0;
            findDone <= 1'b0;
        end else begin
            dValid   <= rdEn;
            pkWrite  <= 1'b0;
            findDone <= 1'b0;
            if (findStart) begin
                rdEn   <= 1'b1;
                rdAddr <= '0;
            end else if (rdEn) begin
                rdAddr <= rdAddr + 1'b1;
                if (rdAddr == sifhPkg::addrT'(sifhPkg::RAM_DEPTH - 1)) begin
                    rdEn <= 1'b0;  // whole SRAM issued
                end
            end
            if (dValid && dBin == sifhPkg::binT'(sifhPkg::BIN_NUM - 1)) begin
                pkWrite  <= 1'b1;  // pixel boundary
                findDone <= (dPix == sifhPkg::pixT'(sifhPkg::PIXEL_NUM - 1));
            end
        end
    end

    always_ff @(posedge clk) begin
        dAddr <= rdAddr;
        if (dValid) begin
            maxCount <= nextCount;
            maxBin   <= nextBin;
        end
        pkPixel <= dPix;
        pkBin   <= nextBin;
        pkCount <= nextCount;
    end

endmodule

`default_nettype wire

/* hdl/sifhRegs.sv */
`timescale 1ns/1ps
`default_nettype none

module sifhRegs (
    input  wire                   clk,
    input  wire                   res,
    input  wire                   cfgWrite,
    input  wire sifhPkg::shotT    cfgShots,
    output sifhPkg::shotT         shotLimit,
    input  wire                   pkWrite,
    input  wire sifhPkg::pixT     pkPixel,
    input  wire sifhPkg::binT     pkBin,
    input  wire sifhPkg::countT   pkCount,
    input  wire sifhPkg::pixT     resultPixel,
    output sifhPkg::binT          resultBin,
    output sifhPkg::countT        resultCount
);

    sifhPkg::binT   peakBin   [sifhPkg::PIXEL_NUM];  // peak table, one entry per pixel
    sifhPkg::countT peakCount [sifhPkg::PIXEL_NUM];

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            shotLimit <= '0;
            for (int i = 0; i < sifhPkg::PIXEL_NUM; i++) begin
                peakBin[i]   <= '0;
                peakCount[i] <= '0;
            end
        end else begin
            if (cfgWrite) begin
                shotLimit <= cfgShots;  // used from the next start
            end
            if (pkWrite) begin
                peakBin[pkPixel]   <= pkBin;
                peakCount[pkPixel] <= pkCount;
            end
        end
    end

    // readback
    assign resultBin   = peakBin[resultPixel];
    assign resultCount = peakCount[resultPixel];

endmodule

`default_nettype wire

/* hdl/sifhCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module sifhCtrl (
    input  wire                   clk,
    input  wire                   res,
    input  wire                   start,
    input  wire                   photonValid,
    input  wire sifhPkg::pixT     photonPixel,
    input  wire sifhPkg::binT     photonBin,
    input  wire sifhPkg::shotT    shotLimit,
    output logic                  busy,
    output logic                  done,
    output logic                  hitValid,
    output sifhPkg::addrT         hitAddr,
    input  wire                   bldRdEn,
    input  wire sifhPkg::addrT    bldRdAddr,
    input  wire                   bldWrEn,
    input  wire sifhPkg::addrT    bldWrAddr,
    input  wire sifhPkg::countT   bldWrData,
    output logic                  findStart,
    input  wire                   findDone,
    input  wire                   pkRdEn,
    input  wire sifhPkg::addrT    pkRdAddr,
    output logic                  ramWEn,
    output sifhPkg::addrT         ramWAddr,
    output sifhPkg::countT        ramWData,
    output logic                  ramREn,
    output sifhPkg::addrT         ramRAddr
);

    sifhPkg::ctrlStateT state;
    logic               clrRun;     // zero writes in progress
    sifhPkg::addrT      clrAddr;
    sifhPkg::shotT      shotLim;    // limit latched at start
    sifhPkg::shotT      shotCnt;    // accepted photons this frame
    logic               drainCnt;

    assign busy      = (state != sifhPkg::IDLE);
    assign hitAddr   = {photonPixel, photonBin};
    assign hitValid  = (state == sifhPkg::BUILD) && photonValid && (shotCnt != shotLim);
    assign findStart = (state == sifhPkg::DRAIN) && drainCnt;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state    <= sifhPkg::CLEAR;
            clrRun   <= 1'b0;
            clrAddr  <= '0;
            shotLim  <= '0;
            shotCnt  <= '0;
            drainCnt <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                sifhPkg::CLEAR: begin
                    clrRun <= 1'b1;  // first cycle after reset only arms it
                    if (clrRun) begin
                        clrAddr <= clrAddr + 1'b1;
                        if (clrAddr == sifhPkg::addrT'(sifhPkg::RAM_DEPTH - 1)) begin
                            clrRun <= 1'b0;
                            state  <= sifhPkg::IDLE;
                        end
                    end
                end
                sifhPkg::IDLE: begin
                    if (start) begin
                        shotLim <= shotLimit;
                        shotCnt <= '0;
                        state   <= sifhPkg::BUILD;
                    end
                end
                sifhPkg::BUILD: begin
                    drainCnt <= 1'b0;
                    if (hitValid) begin
                        shotCnt <= shotCnt + 1'b1;
                    end
                    if (shotCnt == shotLim) begin
                        state <= sifhPkg::DRAIN;  // limit reached
                    end
                end
                sifhPkg::DRAIN: begin
                    drainCnt <= ~drainCnt;
                    if (drainCnt) begin
                        state <= sifhPkg::FIND;
                    end
                end
                sifhPkg::FIND: begin
                    if (findDone) begin
                        done    <= 1'b1;
                        clrRun  <= 1'b1;  // no arming cycle between frames
                        clrAddr <= '0;
                        state   <= sifhPkg::CLEAR;
                    end
                end
                default: state <= sifhPkg::CLEAR;
            endcase
        end
    end

    // SRAM port ownership by state
    always_comb begin
        ramWEn   = 1'b0;
        ramWAddr = '0;
        ramWData = '0;
        ramREn   = 1'b0;
        ramRAddr = '0;
        case (state)
            sifhPkg::CLEAR: begin
                ramWEn   = clrRun;
                ramWAddr = clrAddr;
            end
            sifhPkg::BUILD, sifhPkg::DRAIN: begin
                ramWEn   = bldWrEn;
                ramWAddr = bldWrAddr;
                ramWData = bldWrData;
                ramREn   = bldRdEn;
                ramRAddr = bldRdAddr;
            end
            sifhPkg::FIND: begin
                ramREn   = pkRdEn;
                ramRAddr = pkRdAddr;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/sifhTop.sv */
`timescale 1ns/1ps
`default_nettype none

module sifhTop (
    input  wire                   clk,
    input  wire                   res,
    input  wire                   cfgWrite,
    input  wire sifhPkg::shotT    cfgShots,
    input  wire                   start,
    input  wire                   photonValid,
    input  wire sifhPkg::pixT     photonPixel,
    input  wire sifhPkg::binT     photonBin,
    input  wire sifhPkg::pixT     resultPixel,
    output wire                   busy,
    output wire                   done,
    output wire sifhPkg::binT     resultBin,
    output wire sifhPkg::countT   resultCount
);

    sifhPkg::shotT  shotLimit;
    logic           hitValid;
    sifhPkg::addrT  hitAddr;
    logic           bldRdEn, bldWrEn;
    sifhPkg::addrT  bldRdAddr, bldWrAddr;
    sifhPkg::countT bldWrData;
    logic           findStart, findDone;
    logic           pkRdEn;
    sifhPkg::addrT  pkRdAddr;
    logic           pkWrite;
    sifhPkg::pixT   pkPixel;
    sifhPkg::binT   pkBin;
    sifhPkg::countT pkCount;
    logic           ramWEn, ramREn;
    sifhPkg::addrT  ramWAddr, ramRAddr;
    sifhPkg::countT ramWData, ramRdData;

    sifhCtrl ctrl (
        .clk(clk), .res(res), .start(start), .photonValid(photonValid),
        .photonPixel(photonPixel), .photonBin(photonBin), .shotLimit(shotLimit),
        .busy(busy), .done(done), .hitValid(hitValid), .hitAddr(hitAddr),
        .bldRdEn(bldRdEn), .bldRdAddr(bldRdAddr), .bldWrEn(bldWrEn),
        .bldWrAddr(bldWrAddr), .bldWrData(bldWrData),
        .findStart(findStart), .findDone(findDone), .pkRdEn(pkRdEn), .pkRdAddr(pkRdAddr),
        .ramWEn(ramWEn), .ramWAddr(ramWAddr), .ramWData(ramWData),
        .ramREn(ramREn), .ramRAddr(ramRAddr)
    );

    sifhRegs regs (
        .clk(clk), .res(res), .cfgWrite(cfgWrite), .cfgShots(cfgShots),
        .shotLimit(shotLimit), .pkWrite(pkWrite), .pkPixel(pkPixel), .pkBin(pkBin),
        .pkCount(pkCount), .resultPixel(resultPixel),
        .resultBin(resultBin), .resultCount(resultCount)
    );

    histBuilder builder (
        .clk(clk), .res(res), .hitValid(hitValid), .hitAddr(hitAddr),
        .rdEn(bldRdEn), .rdAddr(bldRdAddr), .rdData(ramRdData),
        .wrEn(bldWrEn), .wrAddr(bldWrAddr), .wrData(bldWrData)
    );

    peakFinder finder (
        .clk(clk), .res(res), .findStart(findStart),
        .rdEn(pkRdEn), .rdAddr(pkRdAddr), .rdData(ramRdData),
        .pkWrite(pkWrite), .pkPixel(pkPixel), .pkBin(pkBin), .pkCount(pkCount),
        .findDone(findDone)
    );

    histRam ram (
        .clk(clk), .wEn(ramWEn), .wAddr(ramWAddr), .wData(ramWData),
        .rEn(ramREn), .rAddr(ramRAddr), .rData(ramRdData)
    );

endmodule

`default_nettype wire

/* verif/sifhClkGen.sv */
`timescale 1ns/1ps
`default_nettype none

module sifhClkGen (
    output logic clk,
    output logic res
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    initial begin
        res = 1'b0;
        repeat (3) @(posedge clk);  // held over three rising edges
        @(negedge clk);
        res = 1'b1;
    end

endmodule

`default_nettype wire

/* verif/sifh_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module sifhAsserts (
    input wire                     clk,
    input wire                     res,
    input wire sifhPkg::ctrlStateT state,
    input wire sifhPkg::addrT      clrAddr,
    input wire sifhPkg::shotT      shotCnt,
    input wire sifhPkg::shotT      shotLim,
    input wire                     busy,
    input wire                     done,
    input wire                     hitValid
);

    int failCount = 0;  // polled by the testbench

    doneOneCycle: assert property (@(posedge clk) disable iff (!res) done |=> !done)
        else begin
            failCount++;
            $error("done stayed high for more than one cycle");
        end

    doneAfterFind: assert property (@(posedge clk) disable iff (!res)
        done |-> $past(state) == sifhPkg::FIND)
        else begin
            failCount++;
            $error("done pulsed without a preceding FIND state");
        end

    // busy drops only once the last SRAM word has been cleared
    clearBeforeIdle: assert property (@(posedge clk) disable iff (!res)
        $fell(busy) |-> $past(state) == sifhPkg::CLEAR
            && $past(clrAddr) == sifhPkg::addrT'(sifhPkg::RAM_DEPTH - 1))
        else begin
            failCount++;
            $error("busy fell before the whole SRAM was cleared");
        end

    hitOnlyInBuild: assert property (@(posedge clk) disable iff (!res)
        hitValid |-> state == sifhPkg::BUILD && shotCnt < shotLim)
        else begin
            failCount++;
            $error("hitValid raised outside BUILD or past the shot limit");
        end

endmodule

`default_nettype wire

/* verif/sifhTb.sv */
`timescale 1ns/1ps
`default_nettype none

module sifhTb;

    logic           clk, res;
    logic           cfgWrite, start, photonValid;
    sifhPkg::shotT  cfgShots;
    sifhPkg::pixT   photonPixel, resultPixel;
    sifhPkg::binT   photonBin, resultBin;
    sifhPkg::countT resultCount;
    logic           busy, done;

    int seed = 32'h31133d00;
    int hist [sifhPkg::PIXEL_NUM][sifhPkg::BIN_NUM];  // reference histogram
    int cfgLimit;
    int frameLimit;  // limit latched at start, as the controller does
    int accepted;
    bit inBuild;
    int cycles = 0;
    int clearCycles;

    sifhClkGen clkGen (.clk(clk), .res(res));

    sifhTop uut (
        .clk(clk), .res(res), .cfgWrite(cfgWrite), .cfgShots(cfgShots), .start(start),
        .photonValid(photonValid), .photonPixel(photonPixel), .photonBin(photonBin),
        .resultPixel(resultPixel), .busy(busy), .done(done),
        .resultBin(resultBin), .resultCount(resultCount)
    );

    bind sifhCtrl sifhAsserts ctrlChecks (
        .clk(clk), .res(res), .state(state), .clrAddr(clrAddr),
        .shotCnt(shotCnt), .shotLim(shotLim),
        .busy(busy), .done(done), .hitValid(hitValid)
    );

    task automatic abortRun(input string reason);
        $display("SOME TESTS FAILED");
        $fatal(1, reason);
    endtask

    task automatic setLimit(input int value);
        @(negedge clk);
        cfgWrite = 1'b1;
        cfgShots = sifhPkg::shotT'(value);
        @(negedge clk);
        cfgWrite = 1'b0;
        cfgLimit = value;
    endtask

    task automatic startFrame();
        do @(negedge clk); while (busy);
        photonValid = 1'b0;  // IDLE photons end with the start
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        frameLimit = cfgLimit;
        accepted   = 0;
        inBuild    = 1'b1;
        foreach (hist[p, b]) hist[p][b] = 0;  // SRAM was cleared before IDLE
    endtask

    task automatic sendPhoton(input sifhPkg::pixT pix, input sifhPkg::binT bin);
        @(negedge clk);
        photonValid = 1'b1;
        photonPixel = pix;
        photonBin   = bin;
        if (inBuild && accepted < frameLimit) begin
            accepted++;
            if (hist[pix][bin] < sifhPkg::COUNT_MAX) begin
                hist[pix][bin]++;  // saturating bin
            end
        end
    endtask

    task automatic quietCycle();
        @(negedge clk);
        photonValid = 1'b0;
    endtask

    task automatic sendRandom(input int count);
        logic [31:0] r;
        for (int i = 0; i < count; i++) begin
            r = $random(seed);
            sendPhoton(r[1:0], r[5:2]);
            if (r[9:8] == 2'b00) begin
                quietCycle();  // otherwise back-to-back
            end
        end
    endtask

    task automatic strayStart();
        @(negedge clk);
        photonValid = 1'b0;
        start       = 1'b1;  // DUT is busy here
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic waitDone();
        quietCycle();
        while (!done) @(negedge clk);
        inBuild = 1'b0;
    endtask

    task automatic checkResults(input string tag);
        int expBin;
        int expCount;
        for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
            expBin   = 0;
            expCount = hist[p][0];
            for (int b = 1; b < sifhPkg::BIN_NUM; b++) begin
                if (hist[p][b] > expCount) begin  // lowest bin wins a tie
                    expBin   = b;
                    expCount = hist[p][b];
                end
            end
            @(negedge clk);
            resultPixel = sifhPkg::pixT'(p);
            #1;
            assert (resultBin == expBin && resultCount == expCount) else begin
                $display("[FAIL] %0t: %s pixel %0d got bin %0d count %0d, expected %0d/%0d",
                         $time, tag, p, resultBin, resultCount, expBin, expCount);
                abortRun("peak result mismatch");
            end
        end
    endtask

    // 5 frames of at most 300 photons plus clear and find stay far below this
    always @(negedge clk) begin
        cycles++;
        if (cycles >= 6000) begin
            $display("timeout: run did not finish within 6000 cycles");
            abortRun("timeout");
        end else if (uut.ctrl.ctrlChecks.failCount != 0) begin
            $display("a controller protocol assertion failed");
            abortRun("assertion failure");
        end
    end

    initial begin
        cfgWrite    = 1'b0;
        cfgShots    = '0;
        start       = 1'b0;
        photonValid = 1'b0;
        photonPixel = '0;
        photonBin   = '0;
        resultPixel = '0;
        inBuild     = 1'b0;
        cfgLimit    = 0;
        frameLimit  = 0;
        accepted    = 0;
        clearCycles = 0;
        wait (res === 1'b1);
        while (busy) begin
            clearCycles++;
            @(negedge clk);
        end
        assert (clearCycles >= sifhPkg::RAM_DEPTH) else begin
            $display("[FAIL] %0t: busy fell after %0d clear cycles", $time, clearCycles);
            abortRun("clear too short");
        end

        setLimit(0);  // straight through BUILD
        startFrame();
        waitDone();
        checkResults("zero limit");

        setLimit(200);
        startFrame();
        sendRandom(200);
        waitDone();
        checkResults("random frame");

        setLimit(300);  // bypass on every cycle, saturates at 255
        startFrame();
        repeat (300) sendPhoton(2'd2, 4'd5);
        waitDone();
        checkResults("saturation");

        setLimit(20);
        do @(negedge clk); while (busy);
        sendRandom(10);  // IDLE photons, dropped
        startFrame();
        sendRandom(12);
        strayStart();
        sendRandom(8);
        sendRandom(10);  // past the limit, dropped
        waitDone();
        checkResults("dropped events");

        setLimit(150);
        startFrame();
        sendRandom(150);
        waitDone();
        checkResults("second random frame");

        if (uut.ctrl.ctrlChecks.failCount != 0) begin
            $display("a controller protocol assertion failed");
            abortRun("assertion failure");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
hdl/sifhPkg.sv
hdl/histRam.sv
hdl/histBuilder.sv
hdl/peakFinder.sv
hdl/sifhRegs.sv
hdl/sifhCtrl.sv
hdl/sifhTop.sv
verif/sifhClkGen.sv
verif/sifh_asserts.sv
verif/sifhTb.sv
